/* hw/icache_data_array.sv */
`default_nettype none

module icache_data_array #(
	parameter int BURST_WORDS = 4
) (
	input wire i_clk,
	input wire i_we,
	input wire [icache_pkg::WAY_WIDTH-1:0] i_way,
	input wire [icache_pkg::INDEX_WIDTH-1:0] i_index,
	input wire [icache_pkg::beat_width(BURST_WORDS)-1:0] i_beat,
	input wire [32*BURST_WORDS-1:0] i_data,
	input wire i_re,
	input wire [icache_pkg::WAYS-1:0] i_rd_way,
	input wire [icache_pkg::INDEX_WIDTH-1:0] i_rd_index,
	input wire [icache_pkg::WORD_WIDTH-1:0] i_rd_word,
	output logic [31:0] o_word
);

	logic [31:0] r_mem [icache_pkg::WAYS][icache_pkg::SETS][icache_pkg::LINE_WORDS];
	logic [31:0] w_rd_word;

	// way select, zero when no way hits
	always_comb begin
		w_rd_word = '0;
		for (int w = 0; w < icache_pkg::WAYS; w++) begin
			if (i_rd_way[w])
				w_rd_word = w_rd_word | r_mem[w][i_rd_index][i_rd_word];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_we) begin
			for (int k = 0; k < BURST_WORDS; k++)
				r_mem[i_way][i_index][int'(i_beat) * BURST_WORDS + k] <= i_data[k*32 +: 32];
		end
		if (i_re)
			o_word <= w_rd_word;
	end

endmodule

`default_nettype wire

/* hw/icache_lookup.sv */
`default_nettype none

module icache_lookup (
	input wire i_clk,
	input wire i_rst,
	input wire i_req_valid,
	input wire [31:0] i_req_addr,
	input wire i_invalidate,
	input wire i_stall,
	input wire i_busy,
	input wire i_tag_we,
	input wire [icache_pkg::WAY_WIDTH-1:0] i_tag_way,
	input wire [icache_pkg::INDEX_WIDTH-1:0] i_tag_index,
	input wire [icache_pkg::TAG_WIDTH-1:0] i_tag_value,
	output logic o_req_ready,
	output logic o_valid,
	output icache_pkg::icache_addr_u o_addr,
	output logic o_hit,
	output logic [icache_pkg::WAYS-1:0] o_hit_way,
	output logic o_miss
);

	logic r_req_valid;
	icache_pkg::icache_addr_u r_addr;
	logic r_sweep;
	logic [icache_pkg::INDEX_WIDTH-1:0] r_sweep_idx;
	logic [icache_pkg::TAG_WIDTH-1:0] r_tags [icache_pkg::WAYS][icache_pkg::SETS];
	logic [icache_pkg::SETS-1:0] r_tag_valid [icache_pkg::WAYS];
	logic [icache_pkg::WAYS-1:0] w_way_hit;

	// asynchronous tag read, one compare per way
	always_comb begin
		for (int w = 0; w < icache_pkg::WAYS; w++) begin
			w_way_hit[w] = r_tag_valid[w][r_addr.lookup.index] &&
				(r_tags[w][r_addr.lookup.index] == r_addr.lookup.tag);
		end
	end

	assign o_addr = r_addr;
	assign o_hit_way = r_req_valid ? w_way_hit : '0;
	assign o_valid = r_req_valid && !i_stall; // data read issued every free cycle
	assign o_hit = r_req_valid && (|w_way_hit) && !i_stall;
	assign o_miss = r_req_valid && !(|w_way_hit) && !i_busy;
	assign o_req_ready = !r_sweep && !i_invalidate && (!r_req_valid || o_hit);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_req_valid <= 1'b0;
			r_sweep <= 1'b1; // clear all sets after reset
			r_sweep_idx <= '0;
		end else begin
			if (i_req_valid && o_req_ready)
				r_req_valid <= 1'b1;
			else if (o_hit)
				r_req_valid <= 1'b0;

			if (r_sweep) begin
				r_sweep_idx <= r_sweep_idx + 1'b1;
				if (&r_sweep_idx) // last set
					r_sweep <= 1'b0;
			end else if (i_invalidate && !r_req_valid) begin
				r_sweep <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_req_valid && o_req_ready)
			r_addr <= i_req_addr;
	end

	always_ff @(posedge i_clk) begin
		if (r_sweep) begin
			for (int w = 0; w < icache_pkg::WAYS; w++)
				r_tag_valid[w][r_sweep_idx] <= 1'b0;
		end else if (i_tag_we) begin
			r_tag_valid[i_tag_way][i_tag_index] <= 1'b1;
		end
		if (i_tag_we)
			r_tags[i_tag_way][i_tag_index] <= i_tag_value;
	end

endmodule

`default_nettype wire

/* hw/icache_pkg.sv */
`default_nettype none

package icache_pkg;

	localparam int WAYS = 4;
	localparam int WAY_WIDTH = $clog2(WAYS);
	localparam int SETS = 64;
	localparam int LINE_WORDS = 8;
	localparam int INDEX_WIDTH = $clog2(SETS);
	localparam int WORD_WIDTH = $clog2(LINE_WORDS);
	localparam int TAG_WIDTH = 32 - INDEX_WIDTH - WORD_WIDTH - 2;
	localparam int LINE_WIDTH = TAG_WIDTH + INDEX_WIDTH; // line number
	localparam int LRU_WIDTH = 3; // tree bits for four ways

	// one fetch address, seen as lookup fields or as line number + offset
	typedef union packed {
		struct packed {
			logic [TAG_WIDTH-1:0] tag;
			logic [INDEX_WIDTH-1:0] index;
			logic [WORD_WIDTH-1:0] word;
			logic [1:0] byte_sel;
		} lookup;
		struct packed {
			logic [LINE_WIDTH-1:0] num;
			logic [31-LINE_WIDTH:0] offset;
		} line;
	} icache_addr_u;

	// bit 1 is the root of the tree
	function automatic logic [WAY_WIDTH-1:0] plru_victim(input logic [LRU_WIDTH-1:0] bits);
		if (bits[1])
			return bits[0] ? 2'd0 : 2'd1;
		return bits[2] ? 2'd2 : 2'd3;
	endfunction

	function automatic logic [LRU_WIDTH-1:0] plru_touch(
		input logic [LRU_WIDTH-1:0] bits,
		input logic [WAY_WIDTH-1:0] way
	);
		case (way)
			2'd0: return {bits[2], 2'b00};
			2'd1: return {bits[2], 2'b01};
			2'd2: return {2'b01, bits[0]};
			default: return {2'b11, bits[0]};
		endcase
	endfunction

	// beat counter width, at least one bit
	function automatic int beat_width(input int burst_words);
		return (LINE_WORDS / burst_words > 1) ? $clog2(LINE_WORDS / burst_words) : 1;
	endfunction

endpackage

`default_nettype wire

/* hw/icache_plru.sv */
`default_nettype none

module icache_plru (
	input wire i_clk,
	input wire i_rst,
	input wire [icache_pkg::INDEX_WIDTH-1:0] i_index,
	input wire i_touch,
	input wire [icache_pkg::WAYS-1:0] i_touch_way,
	output logic [icache_pkg::WAY_WIDTH-1:0] o_victim
);

	logic [icache_pkg::LRU_WIDTH-1:0] r_bits [icache_pkg::SETS];
	logic [icache_pkg::WAY_WIDTH-1:0] w_hit_way;

	// one-hot hit way to index
	always_comb begin
		w_hit_way = '0;
		for (int w = 0; w < icache_pkg::WAYS; w++) begin
			if (i_touch_way[w])
				w_hit_way = w[icache_pkg::WAY_WIDTH-1:0];
		end
	end

	assign o_victim = icache_pkg::plru_victim(r_bits[i_index]);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int s = 0; s < icache_pkg::SETS; s++)
				r_bits[s] <= '0;
		end else if (i_touch) begin
			// victim taken for a refill becomes most recent
			r_bits[i_index] <= icache_pkg::plru_touch(r_bits[i_index], o_victim);
		end else if (|i_touch_way) begin
			r_bits[i_index] <= icache_pkg::plru_touch(r_bits[i_index], w_hit_way);
		end
	end

endmodule

`default_nettype wire

/* hw/icache_refill.sv */
`default_nettype none

module icache_refill #(
	parameter int BURST_WORDS = 4
) (
	input wire i_clk,
	input wire i_rst,
	input wire i_miss,
	input wire icache_pkg::icache_addr_u i_addr,
	input wire [icache_pkg::WAY_WIDTH-1:0] i_victim,
	input wire i_mem_gnt,
	input wire i_mem_valid,
	input wire [32*BURST_WORDS-1:0] i_mem_data,
	output logic o_mem_req,
	output logic [31:0] o_mem_addr,
	output logic o_busy,
	output logic o_touch,
	output logic o_data_we,
	output logic [icache_pkg::WAY_WIDTH-1:0] o_data_way,
	output logic [icache_pkg::INDEX_WIDTH-1:0] o_data_index,
	output logic [icache_pkg::beat_width(BURST_WORDS)-1:0] o_data_beat,
	output logic [32*BURST_WORDS-1:0] o_data,
	output logic o_tag_we,
	output logic [icache_pkg::WAY_WIDTH-1:0] o_tag_way,
	output logic [icache_pkg::INDEX_WIDTH-1:0] o_tag_index,
	output logic [icache_pkg::TAG_WIDTH-1:0] o_tag_value
);

	localparam int BEATS = icache_pkg::LINE_WORDS / BURST_WORDS;
	localparam int BEAT_WIDTH = icache_pkg::beat_width(BURST_WORDS);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ = 2'd1;
	localparam logic [1:0] ST_RECV = 2'd2;

	logic [1:0] r_state;
	logic [BEAT_WIDTH-1:0] r_beat;
	logic [icache_pkg::WAY_WIDTH-1:0] r_way;
	icache_pkg::icache_addr_u r_line;
	logic w_last;

	assign w_last = (r_beat == BEAT_WIDTH'(BEATS - 1));

	assign o_touch = (r_state == ST_IDLE) && i_miss;
	assign o_busy = (r_state != ST_IDLE);
	assign o_mem_req = (r_state == ST_REQ);
	assign o_mem_addr = r_line;

	assign o_data_we = (r_state == ST_RECV) && i_mem_valid;
	assign o_data_way = r_way;
	assign o_data_index = r_line.lookup.index;
	assign o_data_beat = r_beat;
	assign o_data = i_mem_data; // lane k is word k of the beat

	assign o_tag_we = o_data_we && w_last; // line complete
	assign o_tag_way = r_way;
	assign o_tag_index = r_line.lookup.index;
	assign o_tag_value = r_line.lookup.tag;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state <= ST_IDLE;
			r_beat <= '0;
		end else begin
			case (r_state)
				ST_IDLE: begin
					if (i_miss) begin
						r_state <= ST_REQ;
						r_beat <= '0;
					end
				end
				ST_REQ: begin
					if (i_mem_gnt)
						r_state <= ST_RECV;
				end
				ST_RECV: begin
					if (i_mem_valid) begin
						r_beat <= r_beat + 1'b1;
						if (w_last)
							r_state <= ST_IDLE;
					end
				end
				default: r_state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_touch) begin
			r_way <= i_victim;
			r_line.line.num <= i_addr.line.num;
			r_line.line.offset <= '0; // line aligned
		end
	end

endmodule

`default_nettype wire

/* hw/icache_result.sv */
`default_nettype none

module icache_result (
	input wire i_clk,
	input wire i_rst,
	input wire i_load,
	input wire [31:0] i_instr,
	input wire [31:0] i_addr,
	input wire i_rsp_ready,
	output logic o_rsp_valid,
	output logic [31:0] o_rsp_instr,
	output logic [31:0] o_rsp_addr,
	output logic o_stall
);

	logic r_pend; // read in flight, word arrives next cycle
	logic [31:0] r_pend_addr;

	assign o_stall = o_rsp_valid && !i_rsp_ready;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_pend <= 1'b0;
			o_rsp_valid <= 1'b0;
		end else if (!o_stall) begin
			r_pend <= i_load;
			o_rsp_valid <= r_pend;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!o_stall && i_load)
			r_pend_addr <= i_addr;
		if (!o_stall && r_pend) begin
			o_rsp_instr <= i_instr;
			o_rsp_addr <= r_pend_addr;
		end
	end

endmodule

`default_nettype wire

/* hw/icache_top.sv */
`default_nettype none

module icache_top #(
	parameter int BURST_WORDS = 4
) (
	input wire i_clk,
	input wire i_rst,
	input wire i_req_valid,
	input wire [31:0] i_req_addr,
	input wire i_invalidate,
	input wire i_rsp_ready,
	input wire i_mem_gnt,
	input wire i_mem_valid,
	input wire [32*BURST_WORDS-1:0] i_mem_data,
	output logic o_req_ready,
	output logic o_rsp_valid,
	output logic [31:0] o_rsp_instr,
	output logic [31:0] o_rsp_addr,
	output logic o_mem_req,
	output logic [31:0] o_mem_addr
);

	icache_pkg::icache_addr_u w_addr;
	logic w_valid;
	logic w_hit;
	logic [icache_pkg::WAYS-1:0] w_hit_way;
	logic w_miss;
	logic w_busy;
	logic w_stall;
	logic w_touch;
	logic [icache_pkg::WAY_WIDTH-1:0] w_victim;
	logic w_data_we;
	logic [icache_pkg::WAY_WIDTH-1:0] w_data_way;
	logic [icache_pkg::INDEX_WIDTH-1:0] w_data_index;
	logic [icache_pkg::beat_width(BURST_WORDS)-1:0] w_data_beat;
	logic [32*BURST_WORDS-1:0] w_data;
	logic w_tag_we;
	logic [icache_pkg::WAY_WIDTH-1:0] w_tag_way;
	logic [icache_pkg::INDEX_WIDTH-1:0] w_tag_index;
	logic [icache_pkg::TAG_WIDTH-1:0] w_tag_value;
	logic [31:0] w_word;

	icache_lookup i_icache_lookup (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_req_valid(i_req_valid),
		.i_req_addr(i_req_addr),
		.i_invalidate(i_invalidate),
		.i_stall(w_stall),
		.i_busy(w_busy),
		.i_tag_we(w_tag_we),
		.i_tag_way(w_tag_way),
		.i_tag_index(w_tag_index),
		.i_tag_value(w_tag_value),
		.o_req_ready(o_req_ready),
		.o_valid(w_valid),
		.o_addr(w_addr),
		.o_hit(w_hit),
		.o_hit_way(w_hit_way),
		.o_miss(w_miss)
	);

	icache_plru i_icache_plru (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_index(w_addr.lookup.index),
		.i_touch(w_touch),
		.i_touch_way(w_hit_way),
		.o_victim(w_victim)
	);

	icache_refill #(
		.BURST_WORDS(BURST_WORDS)
	) i_icache_refill (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_miss(w_miss),
		.i_addr(w_addr),
		.i_victim(w_victim),
		.i_mem_gnt(i_mem_gnt),
		.i_mem_valid(i_mem_valid),
		.i_mem_data(i_mem_data),
		.o_mem_req(o_mem_req),
		.o_mem_addr(o_mem_addr),
		.o_busy(w_busy),
		.o_touch(w_touch),
		.o_data_we(w_data_we),
		.o_data_way(w_data_way),
		.o_data_index(w_data_index),
		.o_data_beat(w_data_beat),
		.o_data(w_data),
		.o_tag_we(w_tag_we),
		.o_tag_way(w_tag_way),
		.o_tag_index(w_tag_index),
		.o_tag_value(w_tag_value)
	);

	icache_data_array #(
		.BURST_WORDS(BURST_WORDS)
	) i_icache_data_array (
		.i_clk(i_clk),
		.i_we(w_data_we),
		.i_way(w_data_way),
		.i_index(w_data_index),
		.i_beat(w_data_beat),
		.i_data(w_data),
		.i_re(w_valid),
		.i_rd_way(w_hit_way),
		.i_rd_index(w_addr.lookup.index),
		.i_rd_word(w_addr.lookup.word),
		.o_word(w_word)
	);

	icache_result i_icache_result (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_load(w_hit),
		.i_instr(w_word),
		.i_addr(w_addr),
		.i_rsp_ready(i_rsp_ready),
		.o_rsp_valid(o_rsp_valid),
		.o_rsp_instr(o_rsp_instr),
		.o_rsp_addr(o_rsp_addr),
		.o_stall(w_stall)
	);

endmodule

`default_nettype wire

/* verification/icache_assertions.sv */
`default_nettype none

module icache_assertions (
	input wire i_clk,
	input wire i_rst,
	input wire o_req_ready,
	input wire o_rsp_valid,
	input wire [31:0] o_rsp_instr,
	input wire [31:0] o_rsp_addr,
	input wire i_rsp_ready,
	input wire o_mem_req,
	input wire [31:0] o_mem_addr,
	input wire i_mem_gnt
);

	// memory request stays up with a fixed address until granted
	a_mem_req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		o_mem_req && !i_mem_gnt |=> o_mem_req && $stable(o_mem_addr))
		else $error("memory request dropped or changed before grant");

	a_rsp_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_instr)
			&& $stable(o_rsp_addr))
		else $error("response changed under back-pressure");

	a_no_accept_in_refill: assert property (@(posedge i_clk) disable iff (i_rst)
		o_mem_req |-> !o_req_ready)
		else $error("fetch port ready during a refill request");

endmodule

`default_nettype wire

/* verification/icache_tests.svh */
task check_reset_sweep();
	int n;
	n = 0;
	@(negedge i_clk);
	while (!o_req_ready) begin
		check(o_rsp_valid, 0, "o_rsp_valid");
		check(o_mem_req, 0, "o_mem_req");
		n++;
		@(negedge i_clk);
	end
	check(n, icache_pkg::SETS, "sweep_cycles");
endtask

task fetch_random_lines();
	logic [31:0] a;
	rsp_random = 1'b1;
	for (int i = 0; i < NUM_RANDOM; i++) begin
		a = 32'h0004_0000 | (($random(seed) & 7) << 11) | (($random(seed) & 7) << 5)
			| (($random(seed) & 7) << 2); // 8 tags over 8 sets
		send_req(a);
		repeat ($random(seed) & 1) next_drive();
	end
	drain();
	rsp_random = 1'b0;
endtask

task measure_hit_latency(input logic [31:0] a);
	int n;
	int reqs_before;
	send_req(a); // fill
	drain();
	reqs_before = mem_reqs;
	send_req(a + 32'd4);
	n = 0;
	@(negedge i_clk);
	while (!o_rsp_valid) begin
		n++;
		@(negedge i_clk);
	end
	check(n, 2, "hit_latency");
	drain();
	check(mem_reqs, reqs_before, "o_mem_req_count");
endtask

task flush_and_refetch(input logic [31:0] a);
	int n;
	int reqs_before;
	i_invalidate = 1'b1;
	next_drive();
	i_invalidate = 1'b0;
	for (int w = 0; w < icache_pkg::WAYS; w++)
		for (int s = 0; s < icache_pkg::SETS; s++)
			m_valid[w][s] = 1'b0;
	n = 0;
	@(negedge i_clk);
	while (!o_req_ready) begin
		n++;
		@(negedge i_clk);
	end
	check(n, icache_pkg::SETS, "invalidate_cycles");
	next_drive();
	reqs_before = mem_reqs;
	send_req(a);
	drain();
	check(mem_reqs, reqs_before + 1, "o_mem_req_count");
endtask

task evict_by_plru();
	logic [31:0] victim_addr;
	logic [1:0] v;
	int reqs_before;
	for (int i = 0; i < 4; i++)
		send_req({21'h100 + 21'(i), 6'd5, 5'd0});
	drain();
	v = pick_victim(m_lru[5]);
	victim_addr = {m_tag[v][5], 6'd5, 5'd0};
	reqs_before = mem_reqs;
	send_req({21'h104, 6'd5, 5'd8});
	drain();
	check(mem_reqs, reqs_before + 1, "o_mem_req_count");
	reqs_before = mem_reqs;
	send_req(victim_addr + 32'd12);
	drain();
	check(mem_reqs, reqs_before + 1, "o_mem_req_count");
endtask

task run_tests();
	check_reset_sweep();
	next_drive();
	fetch_random_lines();
	measure_hit_latency({21'h0a0, 6'd9, 5'd0});
	flush_and_refetch({21'h0a0, 6'd9, 5'd16});
	evict_by_plru();
endtask

/* verification/icache_tb.sv */
`default_nettype none

module icache_tb;

	localparam int BURST = 4;
	localparam int BEATS = icache_pkg::LINE_WORDS / BURST;
	localparam int NUM_RANDOM = 300;
	localparam int LIMIT = 200 * (NUM_RANDOM + 16) + 3 * icache_pkg::SETS;

	logic i_clk, i_rst, i_req_valid, i_invalidate, i_rsp_ready;
	logic [31:0] i_req_addr;
	logic i_mem_gnt, i_mem_valid;
	logic [32*BURST-1:0] i_mem_data;
	wire o_req_ready, o_rsp_valid, o_mem_req;
	wire [31:0] o_rsp_instr, o_rsp_addr, o_mem_addr;

	integer seed = 32'hd736_8087;
	int errors = 0;
	int responses = 0;
	int misses = 0;
	int mem_reqs = 0;
	int cycles = 0;
	logic rsp_random = 1'b0;
	logic last_hit;
	logic [31:0] exp_rsp[$];
	logic [31:0] exp_mem[$];

	// model tags and tree bits
	logic [icache_pkg::TAG_WIDTH-1:0] m_tag [icache_pkg::WAYS][icache_pkg::SETS];
	logic m_valid [icache_pkg::WAYS][icache_pkg::SETS];
	logic [2:0] m_lru [icache_pkg::SETS];

	icache_top #(.BURST_WORDS(BURST)) i_icache_top (.*);

	bind icache_top icache_assertions i_icache_assertions (.*);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("timeout after %0d cycles with %0d responses outstanding",
				cycles, exp_rsp.size());
			$display("Simulation FAILED");
			$finish;
		end
	end

	task check(input logic [31:0] got, input logic [31:0] exp, input string name);
		if (got !== exp) begin
			$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
			errors++;
		end
	endtask

	task next_drive();
		@(posedge i_clk);
		#1;
	endtask

	function automatic logic [31:0] mem_word(input logic [31:0] word_addr);
		return {word_addr[15:0], ~word_addr[15:0]};
	endfunction

	// bit 1 is the tree root
	function automatic logic [1:0] pick_victim(input logic [2:0] b);
		if (b[1] == 1'b0)
			return b[2] ? 2'd2 : 2'd3;
		return b[0] ? 2'd0 : 2'd1;
	endfunction

	function automatic logic [2:0] mark_used(input logic [2:0] b, input logic [1:0] way);
		case (way)
			2'd0: return {b[2], 1'b0, 1'b0};
			2'd1: return {b[2], 1'b0, 1'b1};
			2'd2: return {1'b0, 1'b1, b[0]};
			default: return {1'b1, 1'b1, b[0]};
		endcase
	endfunction

	task model_access(input logic [31:0] a);
		logic [5:0] idx;
		logic [1:0] v;
		idx = a[10:5];
		last_hit = 1'b0;
		for (int w = 0; w < icache_pkg::WAYS; w++) begin
			if (m_valid[w][idx] && m_tag[w][idx] == a[31:11]) begin
				last_hit = 1'b1;
				m_lru[idx] = mark_used(m_lru[idx], 2'(w));
			end
		end
		if (!last_hit) begin
			v = pick_victim(m_lru[idx]);
			m_lru[idx] = mark_used(m_lru[idx], v);
			m_tag[v][idx] = a[31:11];
			m_valid[v][idx] = 1'b1;
			exp_mem.push_back({a[31:5], 5'd0});
			misses++;
		end
	endtask

	task send_req(input logic [31:0] a);
		i_req_valid = 1'b1;
		i_req_addr = a;
		@(negedge i_clk);
		while (!o_req_ready)
			@(negedge i_clk);
		model_access(a);
		exp_rsp.push_back(a);
		next_drive();
		i_req_valid = 1'b0;
	endtask

	task drain();
		@(negedge i_clk);
		while (exp_rsp.size() != 0 || exp_mem.size() != 0 || o_mem_req)
			@(negedge i_clk);
		next_drive();
	endtask

	`include "icache_tests.svh"

	// memory model serving one line per request
	initial begin
		logic [31:0] line;
		forever begin
			@(negedge i_clk);
			if (!i_rst && o_mem_req) begin
				mem_reqs++;
				if (exp_mem.size() == 0) begin
					$display("memory request at t=%0t with no miss expected", $time);
					errors++;
				end else begin
					check(o_mem_addr, exp_mem.pop_front(), "o_mem_addr");
				end
				line = o_mem_addr;
				next_drive();
				repeat ($random(seed) & 3) next_drive();
				i_mem_gnt = 1'b1;
				next_drive();
				i_mem_gnt = 1'b0;
				for (int b = 0; b < BEATS; b++) begin
					repeat ($random(seed) & 3) next_drive();
					for (int k = 0; k < BURST; k++)
						i_mem_data[k*32 +: 32] = mem_word((line >> 2) + b * BURST + k);
					i_mem_valid = 1'b1;
					next_drive();
					i_mem_valid = 1'b0;
				end
			end
		end
	end

	initial begin
		forever begin
			next_drive();
			i_rsp_ready = rsp_random ? (($random(seed) & 3) != 0) : 1'b1;
		end
	end

	// response order, data and hold under back-pressure
	initial begin
		logic held;
		logic [31:0] p_instr, p_addr, a;
		held = 1'b0;
		forever begin
			@(negedge i_clk);
			if (i_rst) begin
				held = 1'b0;
			end else begin
				if (held) begin
					check(o_rsp_valid, 1, "o_rsp_valid");
					check(o_rsp_instr, p_instr, "o_rsp_instr");
					check(o_rsp_addr, p_addr, "o_rsp_addr");
				end
				if (o_rsp_valid && i_rsp_ready) begin
					if (exp_rsp.size() == 0) begin
						$display("response at t=%0t with no request outstanding", $time);
						errors++;
					end else begin
						a = exp_rsp.pop_front();
						check(o_rsp_addr, a, "o_rsp_addr");
						check(o_rsp_instr, mem_word(a >> 2), "o_rsp_instr");
					end
					responses++;
				end
				held = o_rsp_valid && !i_rsp_ready;
				p_instr = o_rsp_instr;
				p_addr = o_rsp_addr;
			end
		end
	end

	initial begin
		i_rst = 1'b1;
		i_req_valid = 1'b0;
		i_req_addr = '0;
		i_invalidate = 1'b0;
		i_rsp_ready = 1'b1;
		i_mem_gnt = 1'b0;
		i_mem_valid = 1'b0;
		i_mem_data = '0;
		for (int s = 0; s < icache_pkg::SETS; s++) begin
			m_lru[s] = 3'b000;
			for (int w = 0; w < icache_pkg::WAYS; w++)
				m_valid[w][s] = 1'b0;
		end
		repeat (8) next_drive();
		i_rst = 1'b0;
		run_tests();
		$display("errors=%0d responses=%0d misses=%0d", errors, responses, misses);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verification
hw/icache_pkg.sv
hw/icache_lookup.sv
hw/icache_plru.sv
hw/icache_refill.sv
hw/icache_data_array.sv
hw/icache_result.sv
hw/icache_top.sv
verification/icache_assertions.sv
verification/icache_tb.sv
